//--- Bender.yml
package:
  name: branch_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/branch_uop_pkg.sv
      - verilog/branch_stage_if.sv
      - verilog/branch_decode.sv
      - verilog/branch_execute.sv
      - verilog/branch_result.sv
      - verilog/branch_unit_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/branch_unit_checker.sv
      - tb/branch_unit_tb.sv

//--- src.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/branch_uop_pkg.sv
verilog/branch_stage_if.sv
verilog/branch_decode.sv
verilog/branch_execute.sv
verilog/branch_result.sv
verilog/branch_unit_top.sv
tb/branch_unit_checker.sv
tb/branch_unit_tb.sv

//--- tb/branch_unit_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_settings.svh"

module branch_unit_checker (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      i_retire,
    input  wire logic                      i_wb_valid,
    input  wire logic [`BR_REG_ADDR_W-1:0] i_wb_rd,
    input  wire logic                      i_redirect,
    input  wire logic                      i_mispredict,
    input  wire logic                      i_exception
);
    // A redirect always belongs to a retiring instruction
    redirect_has_retire: assert property (@(posedge clk) disable iff (!rst_n)
        i_redirect |-> i_retire)
        else $error("redirect seen without retire");

    // x0 is never written
    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        i_wb_valid |-> (i_wb_rd != '0))
        else $error("write-back to register zero");

    exc_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
        !(i_exception && i_wb_valid))
        else $error("write-back together with an exception");

    // Status outputs stay low during reset
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(i_retire | i_wb_valid | i_redirect | i_mispredict | i_exception))
        else $error("outputs active during reset");

endmodule

bind branch_unit_top branch_unit_checker i_branch_unit_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_retire     (o_retire),
    .i_wb_valid   (o_wb_valid),
    .i_wb_rd      (o_wb_rd),
    .i_redirect   (o_redirect),
    .i_mispredict (o_mispredict),
    .i_exception  (o_exception)
);

`default_nettype wire

//--- tb/branch_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_settings.svh"

module branch_unit_tb import rv_isa_pkg::*, branch_uop_pkg::*;;
    localparam int RETIRE_TIMEOUT = 20;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      i_valid;
    logic [`BR_XLEN-1:0]       i_instr;
    logic [`BR_XLEN-1:0]       i_pc;
    logic [`BR_XLEN-1:0]       i_rs1_data;
    logic [`BR_XLEN-1:0]       i_rs2_data;
    logic                      i_predict_taken;
    logic                      o_retire;
    logic                      o_wb_valid;
    logic [`BR_REG_ADDR_W-1:0] o_wb_rd;
    logic [`BR_XLEN-1:0]       o_wb_data;
    logic                      o_redirect;
    logic [`BR_XLEN-1:0]       o_redirect_pc;
    logic                      o_mispredict;
    logic                      o_exception;
    br_exc_t                   o_exc_cause;

    integer seed;
    int     error_count;
    int     check_count;
    int     test_count;

    // Expected response of the instruction under test
    logic                      exp_wb_valid;
    logic [`BR_REG_ADDR_W-1:0] exp_wb_rd;
    logic [`BR_XLEN-1:0]       exp_wb_data;
    logic                      exp_redirect;
    logic [`BR_XLEN-1:0]       exp_redirect_pc;
    logic                      exp_mispredict;
    logic                      exp_exception;
    br_exc_t                   exp_cause;

    always #5 clk = ~clk;

    branch_unit_top i_branch_unit_top (.*);

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic logic [31:0] next_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    // Instruction encoders, rs1 = x1 and rs2 = x2
    function automatic logic [31:0] encode_op(input logic [2:0] f3, input logic [4:0] rd);
        return {7'b0000000, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_branch(input logic [2:0] f3, input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encode_jalr(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, rd, 7'b1100111};
    endfunction

    function automatic logic [31:0] encode_system(input logic [11:0] code);
        return {code, 13'd0, 7'b1110011};
    endfunction

    // Reference model of one retired instruction
    task automatic compute_expected(input br_cmd_t cmd, input logic [31:0] pc, rs1, rs2, imm,
                                    input logic [4:0] rd, input logic pred);
        logic        taken;
        logic        checked;
        logic        forced;
        logic        writes;
        logic [31:0] wb_value;
        logic [31:0] target;
        taken    = 1'b0;
        checked  = 1'b0;
        forced   = 1'b0;
        writes   = 1'b0;
        wb_value = pc + `BR_PC_INC;
        target   = pc + `BR_PC_INC;
        case (cmd)
            CMD_SLT: begin
                writes   = 1'b1;
                wb_value = ($signed(rs1) < $signed(rs2)) ? 32'd1 : 32'd0;
            end
            CMD_SLTU: begin
                writes   = 1'b1;
                wb_value = (rs1 < rs2) ? 32'd1 : 32'd0;
            end
            CMD_BEQ:  taken = (rs1 == rs2);
            CMD_BNE:  taken = (rs1 != rs2);
            CMD_BLT:  taken = ($signed(rs1) < $signed(rs2));
            CMD_BGE:  taken = ($signed(rs1) >= $signed(rs2));
            CMD_BLTU: taken = (rs1 < rs2);
            CMD_BGEU: taken = (rs1 >= rs2);
            CMD_JAL: begin
                taken  = 1'b1;
                writes = 1'b1;
            end
            CMD_JALR: begin
                forced = 1'b1;
                writes = 1'b1;
                target = (rs1 + imm) & ~32'h1;
            end
            CMD_ECALL:  forced = 1'b1;
            CMD_EBREAK: forced = 1'b1;
            CMD_MRET:   forced = 1'b1;
            default: ;
        endcase
        checked = (cmd inside {CMD_BEQ, CMD_BNE, CMD_BLT, CMD_BGE, CMD_BLTU, CMD_BGEU, CMD_JAL});
        if (checked && taken) target = pc + imm;
        if (cmd == CMD_ECALL) target = `BR_ECALL_VEC;
        if (cmd == CMD_EBREAK) target = `BR_EBREAK_VEC;
        if (cmd == CMD_MRET) target = `BR_MRET_VEC;
        taken = taken | forced;

        exp_wb_rd      = rd;
        exp_wb_data    = wb_value;
        exp_wb_valid   = 1'b0;
        exp_mispredict = 1'b0;
        exp_exception  = 1'b1;
        exp_redirect   = 1'b1;
        // Traps go through the EBREAK vector
        exp_redirect_pc = `BR_EBREAK_VEC;
        if (cmd == CMD_ILLEGAL) begin
            exp_cause = EXC_ILLEGAL;
        end else if (taken && target[1:0] != 2'b00) begin
            exp_cause = EXC_MISALIGNED;
        end else begin
            exp_cause       = EXC_NONE;
            exp_exception   = 1'b0;
            exp_wb_valid    = writes && (rd != 5'd0);
            exp_mispredict  = forced | (checked & (taken != pred));
            exp_redirect    = exp_mispredict;
            exp_redirect_pc = target;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_outputs(input string what);
        check_value({what, " wb_valid"}, o_wb_valid, exp_wb_valid);
        if (exp_wb_valid) begin
            check_value({what, " wb_rd"}, o_wb_rd, exp_wb_rd);
            check_value({what, " wb_data"}, o_wb_data, exp_wb_data);
        end
        check_value({what, " redirect"}, o_redirect, exp_redirect);
        if (exp_redirect) check_value({what, " redirect_pc"}, o_redirect_pc, exp_redirect_pc);
        check_value({what, " mispredict"}, o_mispredict, exp_mispredict);
        check_value({what, " exception"}, o_exception, exp_exception);
        check_value({what, " exc_cause"}, o_exc_cause, exp_cause);
    endtask

    task automatic report_timeout(input string what);
        $display("%s: instruction did not retire within %0d cycles", what, RETIRE_TIMEOUT);
        error_count++;
    endtask

    // Called on a falling edge
    task automatic drive_inputs(input logic [31:0] instr, pc, rs1, rs2, input logic pred);
        i_valid         = 1'b1;
        i_instr         = instr;
        i_pc            = pc;
        i_rs1_data      = rs1;
        i_rs2_data      = rs2;
        i_predict_taken = pred;
    endtask

    task automatic wait_retire(output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            ok = o_retire;
            cycles++;
        end
    endtask

    task automatic run_one(input string what, input br_cmd_t cmd, input logic [31:0] instr,
                           input logic [31:0] pc, rs1, rs2, imm, input logic [4:0] rd,
                           input logic pred);
        logic ok;
        compute_expected(cmd, pc, rs1, rs2, imm, rd, pred);
        drive_inputs(instr, pc, rs1, rs2, pred);
        @(negedge clk);
        i_valid = 1'b0;
        wait_retire(ok);
        if (ok) begin
            check_outputs(what);
        end else begin
            report_timeout(what);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        $display("Test %0d %s done, %0d errors", test_count, name, error_count - errs_before);
    endtask

    task automatic test_set_less_than();
        int          errs;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        errs = error_count;
        for (int n = 0; n < 8; n++) begin
            a = next_random();
            b = next_random();
            // Mixed sign bits make signed and unsigned order disagree
            a[31] = n[0];
            b[31] = n[1];
            if (n == 7) b = a;
            rd = 5'd1 + n[4:0];
            run_one("slt", CMD_SLT, encode_op(3'b010, rd), next_pc(), a, b, 32'd0, rd, n[2]);
            run_one("sltu", CMD_SLTU, encode_op(3'b011, rd), next_pc(), a, b, 32'd0, rd, n[2]);
        end
        finish_test("slt/sltu", errs);
    endtask

    task automatic test_branches();
        int          errs;
        br_cmd_t     cmds [6];
        logic [2:0]  f3s [6];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] imm;
        errs = error_count;
        cmds = '{CMD_BEQ, CMD_BNE, CMD_BLT, CMD_BGE, CMD_BLTU, CMD_BGEU};
        f3s  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < 8; n++) begin
                a   = next_random();
                b   = n[0] ? a : next_random();
                r   = next_random();
                imm = {{19{r[12]}}, r[12:2], 2'b00};
                run_one("branch", cmds[k], encode_branch(f3s[k], imm[12:0]), next_pc(),
                        a, b, imm, 5'd0, n[1]);
            end
        end
        finish_test("branches", errs);
    endtask

    task automatic test_jumps();
        int          errs;
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] imm;
        logic [4:0]  rd;
        errs = error_count;
        for (int n = 0; n < 4; n++) begin
            r   = next_random();
            imm = {{11{r[20]}}, r[20:2], 2'b00};
            rd  = (n == 3) ? 5'd0 : (r[27:23] | 5'd1);
            run_one("jal", CMD_JAL, encode_jal(rd, imm[20:0]), next_pc(), 32'd0, 32'd0,
                    imm, rd, n[0]);
            // Odd offset, bit 0 of the target is dropped
            r   = next_random();
            imm = {{20{r[11]}}, r[11:2], 1'b0, n[1]};
            a   = next_random() & ~32'h3;
            run_one("jalr", CMD_JALR, encode_jalr(rd, imm[11:0]), next_pc(), a, 32'd0,
                    imm, rd, n[0]);
        end
        finish_test("jal/jalr", errs);
    endtask

    task automatic test_system();
        int          errs;
        logic [31:0] r;
        errs = error_count;
        run_one("ecall", CMD_ECALL, encode_system(12'h000), next_pc(), next_random(),
                next_random(), 32'd0, 5'd0, 1'b0);
        run_one("ebreak", CMD_EBREAK, encode_system(12'h001), next_pc(), next_random(),
                next_random(), 32'd0, 5'd0, 1'b1);
        run_one("mret", CMD_MRET, encode_system(12'h302), next_pc(), next_random(),
                next_random(), 32'd0, 5'd0, 1'b0);
        // LOAD opcode is outside this unit
        r      = next_random();
        r[6:0] = 7'b0000011;
        run_one("load", CMD_ILLEGAL, r, next_pc(), next_random(), next_random(), 32'd0,
                r[11:7], 1'b0);
        // SUB-style funct7 on SLT
        run_one("bad funct7", CMD_ILLEGAL, encode_op(3'b010, 5'd3) | 32'h4000_0000,
                next_pc(), next_random(), next_random(), 32'd0, 5'd3, 1'b0);
        finish_test("system/illegal", errs);
    endtask

    task automatic test_misaligned();
        int          errs;
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] imm;
        errs = error_count;
        for (int n = 0; n < 2; n++) begin
            a   = next_random();
            r   = next_random();
            imm = {{19{r[12]}}, r[12:2], 2'b10};
            run_one("misaligned beq", CMD_BEQ, encode_branch(3'b000, imm[12:0]), next_pc(),
                    a, a, imm, 5'd0, n[0]);
        end
        r   = next_random();
        imm = {{11{r[20]}}, r[20:2], 2'b10};
        run_one("misaligned jal", CMD_JAL, encode_jal(5'd4, imm[20:0]), next_pc(), 32'd0,
                32'd0, imm, 5'd4, 1'b1);
        finish_test("misaligned", errs);
    endtask

    task automatic test_back_to_back();
        int          errs;
        logic        ok;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        errs = error_count;
        pc   = next_pc();
        a    = next_random();
        imm  = 32'd64;
        // Taken BEQ predicted not taken, then two younger SLTs
        compute_expected(CMD_BEQ, pc, a, a, imm, 5'd0, 1'b0);
        drive_inputs(encode_branch(3'b000, imm[12:0]), pc, a, a, 1'b0);
        @(negedge clk);
        drive_inputs(encode_op(3'b010, 5'd5), pc + 4, next_random(), next_random(), 1'b0);
        @(negedge clk);
        drive_inputs(encode_op(3'b011, 5'd6), pc + 8, next_random(), next_random(), 1'b0);
        wait_retire(ok);
        if (!ok) begin
            i_valid = 1'b0;
            report_timeout("b2b branch");
        end else begin
            check_outputs("b2b branch");
            a = next_random();
            b = next_random();
            compute_expected(CMD_SLT, pc + imm, a, b, 32'd0, 5'd7, 1'b0);
            drive_inputs(encode_op(3'b010, 5'd7), pc + imm, a, b, 1'b0);
            @(negedge clk);
            i_valid = 1'b0;
            // Slot of the first flushed SLT
            check_value("b2b flushed retire", o_retire, 1'b0);
            wait_retire(ok);
            if (ok) begin
                check_outputs("b2b slt");
            end else begin
                report_timeout("b2b slt");
            end
        end
        finish_test("back to back", errs);
    endtask

    initial begin
        seed            = 32'h864f_cfdd;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        rst_n           = 1'b0;
        i_valid         = 1'b0;
        i_instr         = '0;
        i_pc            = '0;
        i_rs1_data      = '0;
        i_rs2_data      = '0;
        i_predict_taken = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_set_less_than();
        test_branches();
        test_jumps();
        test_system();
        test_misaligned();
        test_back_to_back();

        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/branch_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_settings.svh"

module branch_decode import rv_isa_pkg::*, branch_uop_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      i_valid,
    input  wire logic [`BR_XLEN-1:0]       i_instr,
    input  wire logic [`BR_XLEN-1:0]       i_pc,
    input  wire logic [`BR_XLEN-1:0]       i_rs1_data,
    input  wire logic [`BR_XLEN-1:0]       i_rs2_data,
    input  wire logic                      i_predict_taken,
    input  wire logic                      i_flush,
    branch_issue_if.producer               o_issue
);
    br_cmd_t                   cmd_d;
    logic [`BR_XLEN-1:0]       imm_d;
    logic [`BR_REG_ADDR_W-1:0] rd_d;
    logic [2:0]                funct3;
    logic                      dec_valid;

    assign funct3 = i_instr[14:12];

    // Classify and pick the immediate format
    always_comb begin
        cmd_d = CMD_ILLEGAL;
        imm_d = '0;
        rd_d  = '0;
        case (rv_opcode_t'(i_instr[6:0]))
            OPC_OP: begin
                rd_d = i_instr[11:7];
                if (i_instr[31:25] == F7_BASE && funct3 == F3_SLT) begin
                    cmd_d = CMD_SLT;
                end else if (i_instr[31:25] == F7_BASE && funct3 == F3_SLTU) begin
                    cmd_d = CMD_SLTU;
                end
            end
            OPC_BRANCH: begin
                // B format, bit 0 always zero
                imm_d = {{(`BR_XLEN-12){i_instr[31]}}, i_instr[7], i_instr[30:25],
                         i_instr[11:8], 1'b0};
                case (rv_branch_f3_t'(funct3))
                    F3_BEQ:  cmd_d = CMD_BEQ;
                    F3_BNE:  cmd_d = CMD_BNE;
                    F3_BLT:  cmd_d = CMD_BLT;
                    F3_BGE:  cmd_d = CMD_BGE;
                    F3_BLTU: cmd_d = CMD_BLTU;
                    F3_BGEU: cmd_d = CMD_BGEU;
                    default: cmd_d = CMD_ILLEGAL;
                endcase
            end
            OPC_JAL: begin
                cmd_d = CMD_JAL;
                rd_d  = i_instr[11:7];
                imm_d = {{(`BR_XLEN-20){i_instr[31]}}, i_instr[19:12], i_instr[20],
                         i_instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                rd_d  = i_instr[11:7];
                imm_d = {{(`BR_XLEN-12){i_instr[31]}}, i_instr[31:20]};
                if (funct3 == 3'b000) begin
                    cmd_d = CMD_JALR;
                end
            end
            OPC_SYSTEM: begin
                // rd, rs1 and funct3 must all be zero
                if (i_instr[19:7] == '0) begin
                    case (rv_sys_imm_t'(i_instr[31:20]))
                        SYS_ECALL:  cmd_d = CMD_ECALL;
                        SYS_EBREAK: cmd_d = CMD_EBREAK;
                        SYS_MRET:   cmd_d = CMD_MRET;
                        default:    cmd_d = CMD_ILLEGAL;
                    endcase
                end
            end
            default: cmd_d = CMD_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= i_valid;
        end
    end

    // Operands carry no reset
    always_ff @(posedge clk) begin
        o_issue.cmd           <= cmd_d;
        o_issue.pc            <= i_pc;
        o_issue.arg0          <= i_rs1_data;
        o_issue.arg1          <= i_rs2_data;
        o_issue.imm           <= imm_d;
        o_issue.rd            <= rd_d;
        o_issue.predict_taken <= i_predict_taken;
    end

    // Held item is younger than the redirecting one, drop it on flush
    assign o_issue.valid = dec_valid & ~i_flush;

endmodule

`default_nettype wire

//--- verilog/branch_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_settings.svh"

module branch_execute import branch_uop_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          i_flush,
    branch_issue_if.consumer   i_issue,
    branch_exec_if.producer    o_exec
);
    logic [`BR_XLEN-1:0] pc_next;
    logic [`BR_XLEN-1:0] br_target;
    logic [`BR_XLEN-1:0] jalr_sum;
    logic                eq;
    logic                lt_s;
    logic                lt_u;

    logic [`BR_XLEN-1:0] res_c;
    logic [`BR_XLEN-1:0] jmp_c;
    logic                taken_c;
    logic                checked_c;
    logic                forced_c;
    logic                wr_en_c;
    logic                illegal_c;
    logic                mispredict_c;
    logic                misaligned_c;
    br_exc_t             exc_c;

    // Shared compare and adder logic
    assign pc_next   = i_issue.pc + `BR_PC_INC;
    assign br_target = i_issue.pc + i_issue.imm;
    assign jalr_sum  = i_issue.arg0 + i_issue.imm;
    assign eq        = (i_issue.arg0 == i_issue.arg1);
    assign lt_s      = ($signed(i_issue.arg0) < $signed(i_issue.arg1));
    assign lt_u      = (i_issue.arg0 < i_issue.arg1);

    always_comb begin
        res_c     = '0;
        jmp_c     = pc_next;
        taken_c   = 1'b0;
        checked_c = 1'b0;
        forced_c  = 1'b0;
        wr_en_c   = 1'b0;
        illegal_c = 1'b0;
        case (i_issue.cmd)
            CMD_SLT: begin
                res_c   = {{(`BR_XLEN-1){1'b0}}, lt_s};
                wr_en_c = 1'b1;
            end
            CMD_SLTU: begin
                res_c   = {{(`BR_XLEN-1){1'b0}}, lt_u};
                wr_en_c = 1'b1;
            end
            // Conditional branches, outcome checked against the prediction
            CMD_BEQ: begin
                checked_c = 1'b1;
                taken_c   = eq;
            end
            CMD_BNE: begin
                checked_c = 1'b1;
                taken_c   = ~eq;
            end
            CMD_BLT: begin
                checked_c = 1'b1;
                taken_c   = lt_s;
            end
            CMD_BGE: begin
                checked_c = 1'b1;
                taken_c   = ~lt_s;
            end
            CMD_BLTU: begin
                checked_c = 1'b1;
                taken_c   = lt_u;
            end
            CMD_BGEU: begin
                checked_c = 1'b1;
                taken_c   = ~lt_u;
            end
            CMD_JAL: begin
                res_c     = pc_next;
                checked_c = 1'b1;
                taken_c   = 1'b1;
                wr_en_c   = 1'b1;
            end
            // Always treated as unpredicted
            CMD_JALR: begin
                res_c    = pc_next;
                jmp_c    = {jalr_sum[`BR_XLEN-1:1], 1'b0};
                taken_c  = 1'b1;
                forced_c = 1'b1;
                wr_en_c  = 1'b1;
            end
            CMD_ECALL: begin
                jmp_c    = `BR_ECALL_VEC;
                taken_c  = 1'b1;
                forced_c = 1'b1;
            end
            CMD_EBREAK: begin
                jmp_c    = `BR_EBREAK_VEC;
                taken_c  = 1'b1;
                forced_c = 1'b1;
            end
            CMD_MRET: begin
                jmp_c    = `BR_MRET_VEC;
                taken_c  = 1'b1;
                forced_c = 1'b1;
            end
            default: illegal_c = 1'b1;
        endcase

        // Predicted paths jump to pc + imm when taken
        if (checked_c && taken_c) begin
            jmp_c = br_target;
        end

        mispredict_c = forced_c | (checked_c & (taken_c ^ i_issue.predict_taken));
        misaligned_c = taken_c & (jmp_c[1:0] != 2'b00);

        if (illegal_c) begin
            exc_c = EXC_ILLEGAL;
        end else if (misaligned_c) begin
            exc_c = EXC_MISALIGNED;
        end else begin
            exc_c = EXC_NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_exec.valid      <= 1'b0;
            o_exec.wr_en      <= 1'b0;
            o_exec.mispredict <= 1'b0;
            o_exec.exc        <= EXC_NONE;
        end else begin
            // Item coming from decode is younger than the redirect
            o_exec.valid      <= i_issue.valid & ~i_flush;
            o_exec.wr_en      <= wr_en_c & (exc_c == EXC_NONE);
            o_exec.mispredict <= mispredict_c & (exc_c == EXC_NONE);
            o_exec.exc        <= exc_c;
        end
    end

    always_ff @(posedge clk) begin
        o_exec.cmd <= i_issue.cmd;
        o_exec.res <= res_c;
        o_exec.jmp <= jmp_c;
        o_exec.rd  <= i_issue.rd;
    end

endmodule

`default_nettype wire

//--- verilog/branch_result.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_settings.svh"

module branch_result import branch_uop_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    branch_exec_if.consumer                i_exec,
    output      logic                      o_flush,
    output      logic                      o_retire,
    output      logic                      o_wb_valid,
    output      logic [`BR_REG_ADDR_W-1:0] o_wb_rd,
    output      logic [`BR_XLEN-1:0]       o_wb_data,
    output      logic                      o_redirect,
    output      logic [`BR_XLEN-1:0]       o_redirect_pc,
    output      logic                      o_mispredict,
    output      logic                      o_exception,
    output      br_exc_t                   o_exc_cause
);
    logic in_valid;
    logic has_exc;
    logic wb_cmd;

    // Squash the item behind a redirect
    assign in_valid = i_exec.valid & ~o_flush;
    assign has_exc  = (i_exec.exc != EXC_NONE);

    // Only these commands own a destination register
    assign wb_cmd = i_exec.cmd inside {CMD_SLT, CMD_SLTU, CMD_JAL, CMD_JALR};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_retire     <= 1'b0;
            o_wb_valid   <= 1'b0;
            o_redirect   <= 1'b0;
            o_mispredict <= 1'b0;
            o_exception  <= 1'b0;
            o_exc_cause  <= EXC_NONE;
        end else begin
            o_retire     <= in_valid;
            o_wb_valid   <= in_valid & wb_cmd & i_exec.wr_en & (i_exec.rd != '0);
            o_redirect   <= in_valid & (i_exec.mispredict | has_exc);
            o_mispredict <= in_valid & i_exec.mispredict;
            o_exception  <= in_valid & has_exc;
            o_exc_cause  <= in_valid ? i_exec.exc : EXC_NONE;
        end
    end

    // Exceptions trap through the EBREAK vector
    always_ff @(posedge clk) begin
        o_wb_rd       <= i_exec.rd;
        o_wb_data     <= i_exec.res;
        o_redirect_pc <= has_exc ? `BR_EBREAK_VEC : i_exec.jmp;
    end

    // One-cycle pulse alongside the redirect
    assign o_flush = o_redirect;

endmodule

`default_nettype wire

//--- verilog/branch_settings.svh
`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// Data and address width of the RV32 core
`define BR_XLEN 32

// Register index width
`define BR_REG_ADDR_W 5

// PC step for link values and not-taken targets
`define BR_PC_INC 32'd4

// Fixed trap and return vectors, no CSR file in this unit
`define BR_ECALL_VEC 32'h0000_0040
`define BR_EBREAK_VEC 32'h0000_0080
`define BR_MRET_VEC 32'h0000_00C0

`endif

//--- verilog/branch_stage_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_settings.svh"

// Decode to execute
interface branch_issue_if import branch_uop_pkg::*; ();
    logic                          valid;
    br_cmd_t                       cmd;
    logic [`BR_XLEN-1:0]           pc;
    logic [`BR_XLEN-1:0]           arg0;
    logic [`BR_XLEN-1:0]           arg1;
    logic [`BR_XLEN-1:0]           imm;
    logic [`BR_REG_ADDR_W-1:0]     rd;
    logic                          predict_taken;

    modport producer (output valid, cmd, pc, arg0, arg1, imm, rd, predict_taken);
    modport consumer (input  valid, cmd, pc, arg0, arg1, imm, rd, predict_taken);
endinterface

// Execute to result
interface branch_exec_if import branch_uop_pkg::*; ();
    logic                          valid;
    br_cmd_t                       cmd;
    // Value for rd
    logic [`BR_XLEN-1:0]           res;
    // Redirect target
    logic [`BR_XLEN-1:0]           jmp;
    logic [`BR_REG_ADDR_W-1:0]     rd;
    logic                          wr_en;
    logic                          mispredict;
    br_exc_t                       exc;

    modport producer (output valid, cmd, res, jmp, rd, wr_en, mispredict, exc);
    modport consumer (input  valid, cmd, res, jmp, rd, wr_en, mispredict, exc);
endinterface

`default_nettype wire

//--- verilog/branch_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_settings.svh"

module branch_unit_top import branch_uop_pkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      i_valid,
    input  wire logic [`BR_XLEN-1:0]       i_instr,
    input  wire logic [`BR_XLEN-1:0]       i_pc,
    input  wire logic [`BR_XLEN-1:0]       i_rs1_data,
    input  wire logic [`BR_XLEN-1:0]       i_rs2_data,
    input  wire logic                      i_predict_taken,
    output      logic                      o_retire,
    output      logic                      o_wb_valid,
    output      logic [`BR_REG_ADDR_W-1:0] o_wb_rd,
    output      logic [`BR_XLEN-1:0]       o_wb_data,
    output      logic                      o_redirect,
    output      logic [`BR_XLEN-1:0]       o_redirect_pc,
    output      logic                      o_mispredict,
    output      logic                      o_exception,
    output      br_exc_t                   o_exc_cause
);
    // Redirect kill for the younger stages
    logic flush;

    branch_issue_if issue_bus ();
    branch_exec_if  exec_bus ();

    branch_decode i_branch_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_valid         (i_valid),
        .i_instr         (i_instr),
        .i_pc            (i_pc),
        .i_rs1_data      (i_rs1_data),
        .i_rs2_data      (i_rs2_data),
        .i_predict_taken (i_predict_taken),
        .i_flush         (flush),
        .o_issue         (issue_bus.producer)
    );

    branch_execute i_branch_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_flush (flush),
        .i_issue (issue_bus.consumer),
        .o_exec  (exec_bus.producer)
    );

    branch_result i_branch_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_exec        (exec_bus.consumer),
        .o_flush       (flush),
        .o_retire      (o_retire),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_mispredict  (o_mispredict),
        .o_exception   (o_exception),
        .o_exc_cause   (o_exc_cause)
    );

endmodule

`default_nettype wire

//--- verilog/branch_uop_pkg.sv
`default_nettype none

package branch_uop_pkg;

    // Internal command passed from decode to execute
    typedef enum logic [3:0] {
        CMD_SLT,
        CMD_SLTU,
        CMD_BEQ,
        CMD_BNE,
        CMD_BLT,
        CMD_BGE,
        CMD_BLTU,
        CMD_BGEU,
        CMD_JAL,
        CMD_JALR,
        CMD_ECALL,
        CMD_EBREAK,
        CMD_MRET,
        CMD_ILLEGAL
    } br_cmd_t;

    // Exception cause reported at retire
    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ILLEGAL,
        EXC_MISALIGNED
    } br_exc_t;

endpackage

`default_nettype wire

//--- verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes handled by the branch unit
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_t;

    // funct3 codes of the conditional branches
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } rv_branch_f3_t;

    // Immediate field of the SYSTEM instructions
    typedef enum logic [11:0] {
        SYS_ECALL  = 12'h000,
        SYS_EBREAK = 12'h001,
        SYS_MRET   = 12'h302
    } rv_sys_imm_t;

    // Set-less-than codes on the OP opcode
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [6:0] F7_BASE = 7'b0000000;

endpackage

`default_nettype wire
